// File: flist.f
verilog/rvv_isa_pkg.sv
verilog/mask_unit_pkg.sv
verilog/mask_uop_decode.sv
verilog/mask_logic_unit.sv
verilog/mask_set_first_unit.sv
verilog/mask_popcount.sv
verilog/mask_result_stage.sv
verilog/mask_unit.sv
test/tb_clock_gen.sv
test/tb_mask_checker.sv
test/tb_mask_unit.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mask unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mask_unit -f flist.f -o tb_mask_unit

output=$(./obj_dir/tb_mask_unit)
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  // 4 ns period
  initial clk = 1'b0;

  always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: test/tb_mask_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mask_checker (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        uop_valid,
  input  logic                        uop_ready,
  input  logic                        result_valid,
  input  logic                        result_ready,
  input  mask_unit_pkg::rob_result_t  result,
  input  mask_unit_pkg::rob_result_t  exp_result,
  output int                          errors,
  output int                          checked,
  output int                          pending
);

  import mask_unit_pkg::*;

  rob_result_t exp_q[$];
  rob_result_t want;
  rob_result_t held;
  logic        stalled = 1'b0;
  logic        exp_ready;
  int          err_cnt = 0;
  int          chk_cnt = 0;

  assign errors  = err_cnt;
  assign checked = chk_cnt;
  assign pending = exp_q.size();

  // everything is sampled mid-cycle, inputs change 1 ns after the rising edge
  always @(negedge clk) begin
    if (!arst_n) begin
      if (result_valid !== 1'b0 || uop_ready !== 1'b1 || result !== '0) begin
        $display("Reset state wrong at %0t: result_valid=%b uop_ready=%b result=%h",
                 $time, result_valid, uop_ready, result);
        err_cnt++;
      end
      exp_q.delete();
      stalled = 1'b0;
    end else begin
      exp_ready = !(result_valid && !result_ready);
      if (uop_ready !== exp_ready) begin
        $display("Mismatch at %0t: uop_ready got %b expected %b", $time, uop_ready, exp_ready);
        err_cnt++;
      end
      // a stalled result must not move
      if (stalled && (result_valid !== 1'b1 || result !== held)) begin
        $display("Held result changed at %0t while result_ready was low", $time);
        err_cnt++;
      end
      if (result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          $display("Result at %0t came back with no micro-op outstanding", $time);
          err_cnt++;
        end else begin
          want = exp_q.pop_front();
          chk_cnt++;
          if (result.rob_entry !== want.rob_entry) begin
            $display("Mismatch at %0t: result.rob_entry got %0d expected %0d",
                     $time, result.rob_entry, want.rob_entry);
            err_cnt++;
          end
          if (result.w_data !== want.w_data) begin
            $display("Mismatch at %0t: result.w_data got %h expected %h",
                     $time, result.w_data, want.w_data);
            err_cnt++;
          end
        end
      end
      stalled = result_valid && !result_ready;
      held    = result;
      // accepted at the coming edge
      if (uop_valid && uop_ready) begin
        exp_q.push_back(exp_result);
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_mask_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mask_unit;

  import mask_unit_pkg::*;
  import rvv_isa_pkg::*;

  localparam int UOPS_PER_TEST = 200;
  localparam int TOTAL_UOPS    = 6 * UOPS_PER_TEST;
  localparam int RESET_NS      = 2 * 4 * 5;
  localparam int WATCHDOG_NS   = 4 * TOTAL_UOPS * 8 + RESET_NS;

  localparam funct6_e LOGIC_F6 [8] = '{VMANDN, VMAND, VMOR, VMXOR,
                                       VMORN, VMNAND, VMNOR, VMXNOR};
  localparam vs1_op_e SET_FIRST_VS1 [3] = '{VMSBF, VMSIF, VMSOF};

  logic        clk;
  logic        arst_n;
  logic        uop_valid;
  logic        uop_ready;
  logic        result_valid;
  logic        result_ready;
  mask_uop_t   uop;
  rob_result_t result;
  rob_result_t exp_result;
  int          errors;
  int          checked;
  int          pending;
  int unsigned seed = 2505;

  tb_clock_gen clock_gen_inst (
    .clk (clk)
  );

  mask_unit mask_unit_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .uop_valid    (uop_valid),
    .uop_ready    (uop_ready),
    .uop          (uop),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
  );

  tb_mask_checker result_checker_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .uop_valid    (uop_valid),
    .uop_ready    (uop_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result),
    .exp_result   (exp_result),
    .errors       (errors),
    .checked      (checked),
    .pending      (pending)
  );

  // two LCG steps, upper halves only
  function automatic int unsigned rand32();
    int unsigned hi;
    seed = seed * 32'd1103515245 + 32'd12345;
    hi   = seed >> 16;
    seed = seed * 32'd1103515245 + 32'd12345;
    return (hi << 16) | (seed >> 16);
  endfunction

  function automatic logic [VLEN-1:0] rand_vec();
    return {rand32(), rand32(), rand32(), rand32()};
  endfunction

  // reference model built from the RVV mask rules
  function automatic rob_result_t expected(input mask_uop_t u);
    rob_result_t     e;
    logic [VLEN-1:0] act;
    logic [VLEN-1:0] r;
    logic            b;
    logic            scalar;
    int              first;
    int              cnt;
    e.rob_entry = u.rob_entry;
    e.w_data    = '0;
    first       = -1;
    cnt         = 0;
    scalar      = (u.funct6 == VWXUNARY0);
    case (u.funct6)
      VMANDN:  r = u.vs2_data & ~u.vs1_data;
      VMAND:   r = u.vs2_data & u.vs1_data;
      VMOR:    r = u.vs2_data | u.vs1_data;
      VMXOR:   r = u.vs2_data ^ u.vs1_data;
      VMORN:   r = u.vs2_data | ~u.vs1_data;
      VMNAND:  r = ~(u.vs2_data & u.vs1_data);
      VMNOR:   r = ~(u.vs2_data | u.vs1_data);
      VMXNOR:  r = ~(u.vs2_data ^ u.vs1_data);
      default: r = '0;
    endcase
    for (int i = 0; i < VLEN; i++) begin
      act[i] = u.vm || u.v0_data[i];
      if (u.vs2_data[i] && act[i] && (!scalar || i < int'(u.vl))) begin
        cnt++;
        if (first < 0) first = i;
      end
    end
    if (u.funct3 != OPMVV) begin
      e.w_data = '0;
    end else if (u.funct6 inside {VMANDN, VMAND, VMOR, VMXOR, VMORN, VMNAND, VMNOR, VMXNOR}) begin
      for (int i = 0; i < VLEN; i++) begin
        e.w_data[i] = (i < int'(u.vstart)) ? u.vd_data[i] : r[i];
      end
    end else if (u.funct6 == VMUNARY0 && u.vs1 inside {VMSBF, VMSIF, VMSOF}) begin
      for (int i = 0; i < VLEN; i++) begin
        if (u.vs1 == VMSBF) b = (first < 0) || (i < first);
        else if (u.vs1 == VMSIF) b = (first < 0) || (i <= first);
        else b = (i == first);
        e.w_data[i] = act[i] ? b : u.vd_data[i];
      end
    end else if (scalar && u.vs1 == VCPOP) begin
      e.w_data = VLEN'(cnt);
    end else if (scalar && u.vs1 == VFIRST) begin
      e.w_data = (first < 0) ? VLEN'(32'hffff_ffff) : VLEN'(first);
    end
    return e;
  endfunction

  // kinds: 0-7 logicals, 8-10 set-first, 11 vcpop, 12 vfirst, 13 viota (unsupported)
  function automatic mask_uop_t make_uop(input int id);
    mask_uop_t u;
    int        kind;
    int        shape;
    case (id)
      1:       kind = int'(rand32() % 8);
      2:       kind = 8 + int'(rand32() % 3);
      3:       kind = 11;
      4:       kind = 12;
      6:       kind = (rand32() % 2 == 0) ? 13 : int'(rand32() % 14);
      default: kind = int'(rand32() % 14);
    endcase
    u.rob_entry = ROB_DEPTH_WIDTH'(rand32());
    u.funct3    = OPMVV;
    u.vs1       = '0;
    u.vstart    = VSTART_WIDTH'(rand32());
    u.vl        = VL_WIDTH'(rand32() % 129);
    u.vm        = 1'(rand32());
    u.v0_data   = rand_vec();
    u.vd_data   = rand_vec();
    u.vs1_data  = rand_vec();
    u.vs2_data  = rand_vec();
    if (kind < 8) begin
      u.funct6 = LOGIC_F6[kind];
    end else if (kind < 11) begin
      u.funct6 = VMUNARY0;
      u.vs1    = SET_FIRST_VS1[kind-8];
    end else if (kind < 13) begin
      u.funct6 = VWXUNARY0;
      u.vs1    = (kind == 11) ? VCPOP : VFIRST;
    end else begin
      u.funct6 = VMUNARY0;
      u.vs1    = 5'b10000;
    end
    // zero, sparse and fully masked sources
    shape = int'(rand32() % 4);
    if (kind >= 8 && shape == 0) u.vs2_data = '0;
    if (kind >= 8 && shape == 1) u.vs2_data = u.vs2_data & rand_vec() & rand_vec();
    if (kind >= 8 && shape == 2) begin
      u.vm      = 1'b0;
      u.v0_data = '0;
    end
    return u;
  endfunction

  task automatic apply_reset();
    uop_valid    = 1'b0;
    result_ready = 1'b0;
    arst_n       = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  // starts and ends 1 ns after a rising edge
  task automatic issue(input mask_uop_t u);
    logic taken;
    taken = 1'b0;
    while (rand32() % 4 == 0) begin
      uop_valid    = 1'b0;
      result_ready = (rand32() % 10) < 7;
      @(posedge clk);
      #1;
    end
    uop        = u;
    exp_result = expected(u);
    uop_valid  = 1'b1;
    while (!taken) begin
      result_ready = (rand32() % 10) < 7;
      @(negedge clk);
      taken = uop_valid && uop_ready;
      @(posedge clk);
      #1;
    end
    uop_valid = 1'b0;
  endtask

  task automatic drain();
    uop_valid = 1'b0;
    while (pending != 0) begin
      result_ready = (rand32() % 10) < 7;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_test(input int id, input string name);
    int errors_before;
    errors_before = errors;
    for (int n = 0; n < UOPS_PER_TEST; n++) begin
      issue(make_uop(id));
    end
    drain();
    $display("test %0d %s: %s, %0d errors", id, name,
             (errors == errors_before) ? "ok" : "failed", errors - errors_before);
  endtask

  initial begin
    arst_n       = 1'b1;
    uop_valid    = 1'b0;
    result_ready = 1'b0;
    uop          = '0;
    exp_result   = '0;
    #1;
    apply_reset();
    run_test(1, "mask logicals with vstart");
    run_test(2, "vmsbf vmsif vmsof");
    run_test(3, "vcpop");
    run_test(4, "vfirst");
    run_test(5, "back-pressure and ordering");
    apply_reset();
    run_test(6, "reset state and unsupported op");
    $display("summary: %0d of %0d results checked, %0d errors", checked, TOTAL_UOPS, errors);
    if (errors == 0 && checked == TOTAL_UOPS) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // generous bound on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns: the DUT stopped responding, %0d results outstanding",
             WATCHDOG_NS, pending);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/mask_logic_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mask_logic_unit (
  input  mask_unit_pkg::mask_exec_t          exec,
  output logic [mask_unit_pkg::VLEN-1:0]     logic_data
);

  import mask_unit_pkg::*;

  logic [VLEN-1:0] raw;
  logic [VLEN-1:0] prefix;

  // vs2 op vs1, the n forms invert vs1
  always_comb begin
    case (exec.op)
      OP_ANDN: raw = exec.src2 & ~exec.src1;
      OP_AND:  raw = exec.src2 & exec.src1;
      OP_OR:   raw = exec.src2 | exec.src1;
      OP_XOR:  raw = exec.src2 ^ exec.src1;
      OP_ORN:  raw = exec.src2 | ~exec.src1;
      OP_NAND: raw = ~(exec.src2 & exec.src1);
      OP_NOR:  raw = ~(exec.src2 | exec.src1);
      OP_XNOR: raw = ~(exec.src2 ^ exec.src1);
      default: raw = '0;
    endcase
  end

  // elements before vstart are left as in vd
  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      prefix[i] = (i < int'(exec.vstart));
    end
  end

  assign logic_data = (raw & ~prefix) |
                      (exec.vd_data & prefix &
                       {VLEN{exec.op inside {OP_ANDN, OP_AND, OP_OR, OP_XOR,
                                             OP_ORN, OP_NAND, OP_NOR, OP_XNOR}}});

endmodule

`default_nettype wire

// File: verilog/mask_popcount.sv
`timescale 1ns/100ps
`default_nettype none

module mask_popcount (
  input  mask_unit_pkg::mask_exec_t          exec,
  output logic [mask_unit_pkg::XLEN-1:0]     pop_count
);

  import mask_unit_pkg::*;

  localparam int NCHUNK = VLEN / 16;

  logic [NCHUNK-1:0][4:0]   chunk_cnt;
  logic [NCHUNK/2-1:0][5:0] sum_l1;
  logic [NCHUNK/4-1:0][6:0] sum_l2;
  logic [7:0]               total;

  // ones in a nibble, table form
  function automatic logic [2:0] f_count4(input logic [3:0] src);
    case (src)
      4'b0000:                            f_count4 = 3'd0;
      4'b0001, 4'b0010, 4'b0100, 4'b1000: f_count4 = 3'd1;
      4'b0111, 4'b1011, 4'b1101, 4'b1110: f_count4 = 3'd3;
      4'b1111:                            f_count4 = 3'd4;
      default:                            f_count4 = 3'd2;
    endcase
  endfunction

  function automatic logic [4:0] f_count16(input logic [15:0] src);
    logic [3:0] lo;
    logic [3:0] hi;
    lo = 4'(f_count4(src[3:0])) + 4'(f_count4(src[7:4]));
    hi = 4'(f_count4(src[11:8])) + 4'(f_count4(src[15:12]));
    f_count16 = 5'(lo) + 5'(hi);
  endfunction

  always_comb begin
    for (int j = 0; j < NCHUNK; j++) begin
      chunk_cnt[j] = f_count16(exec.src2[16*j +: 16]);
    end
    // pairwise adder tree
    for (int j = 0; j < NCHUNK / 2; j++) begin
      sum_l1[j] = 6'(chunk_cnt[2*j]) + 6'(chunk_cnt[2*j+1]);
    end
    for (int j = 0; j < NCHUNK / 4; j++) begin
      sum_l2[j] = 7'(sum_l1[2*j]) + 7'(sum_l1[2*j+1]);
    end
    total = 8'(sum_l2[0]) + 8'(sum_l2[1]);
  end

  assign pop_count = XLEN'(total);

endmodule

`default_nettype wire

// File: verilog/mask_result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mask_result_stage (
  input  logic                               clk,
  input  logic                               arst_n,
  input  mask_unit_pkg::mask_exec_t          exec,
  input  logic [mask_unit_pkg::VLEN-1:0]     logic_data,
  input  logic [mask_unit_pkg::VLEN-1:0]     set_first_data,
  input  logic [mask_unit_pkg::XLEN-1:0]     first_index,
  input  logic [mask_unit_pkg::XLEN-1:0]     pop_count,
  input  logic                               uop_valid,
  output logic                               uop_ready,
  output logic                               result_valid,
  input  logic                               result_ready,
  output mask_unit_pkg::rob_result_t         result
);

  import mask_unit_pkg::*;

  logic            full;
  logic            accept;
  logic [VLEN-1:0] w_data;
  rob_result_t     result_q;

  // scalar results are zero-extended into w_data
  always_comb begin
    case (exec.op)
      OP_ANDN, OP_AND, OP_OR, OP_XOR,
      OP_ORN, OP_NAND, OP_NOR, OP_XNOR: begin
        w_data = logic_data;
      end
      OP_MSBF, OP_MSIF, OP_MSOF: begin
        w_data = set_first_data;
      end
      OP_CPOP:  w_data = VLEN'(pop_count);
      OP_FIRST: w_data = VLEN'(first_index);
      default:  w_data = '0;
    endcase
  end

  // slot frees up in the same cycle it drains
  assign uop_ready = ~full | result_ready;
  assign accept    = uop_valid & uop_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full     <= 1'b0;
      result_q <= '0;
    end else begin
      if (accept) begin
        full               <= 1'b1;
        result_q.rob_entry <= exec.rob_entry;
        result_q.w_data    <= w_data;
      end else if (result_ready) begin
        full <= 1'b0;
      end
    end
  end

  assign result_valid = full;
  assign result       = result_q;

endmodule

`default_nettype wire

// File: verilog/mask_set_first_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mask_set_first_unit (
  input  mask_unit_pkg::mask_exec_t          exec,
  output logic [mask_unit_pkg::VLEN-1:0]     set_first_data,
  output logic [mask_unit_pkg::XLEN-1:0]     first_index
);

  import mask_unit_pkg::*;

  logic [VLEN-1:0] src_dec;
  logic [VLEN-1:0] first1;
  logic [VLEN-1:0] sif;
  logic [VLEN-1:0] sbf;
  logic [VLEN-1:0] raw;

  // borrow runs up to the lowest set bit
  assign src_dec = exec.src2 - 1'b1;
  assign first1  = exec.src2 & ~src_dec;
  // zero source gives all ones here without a special case
  assign sif     = exec.src2 ^ src_dec;
  assign sbf     = sif & ~first1;

  always_comb begin
    case (exec.op)
      OP_MSBF: raw = sbf;
      OP_MSIF: raw = sif;
      OP_MSOF: raw = first1;
      default: raw = '0;
    endcase
  end

  // masked-off elements keep vd when vm is 0
  always_comb begin
    if (exec.vm) begin
      set_first_data = raw;
    end else begin
      set_first_data = (raw & exec.v0_data) | (exec.vd_data & ~exec.v0_data);
    end
    if (!(exec.op inside {OP_MSBF, OP_MSIF, OP_MSOF})) begin
      set_first_data = '0;
    end
  end

  // scan from the top so the lowest hit wins
  always_comb begin
    first_index = {XLEN{1'b1}};
    for (int i = VLEN - 1; i >= 0; i--) begin
      if (exec.src2[i]) begin
        first_index = XLEN'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mask_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mask_unit (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        uop_valid,
  output logic                        uop_ready,
  input  mask_unit_pkg::mask_uop_t    uop,
  output logic                        result_valid,
  input  logic                        result_ready,
  output mask_unit_pkg::rob_result_t  result
);

  import mask_unit_pkg::*;

  mask_exec_t      exec;
  logic [VLEN-1:0] logic_data;
  logic [VLEN-1:0] set_first_data;
  logic [XLEN-1:0] first_index;
  logic [XLEN-1:0] pop_count;

  mask_uop_decode mask_uop_decode_inst (
    .uop  (uop),
    .exec (exec)
  );

  mask_logic_unit mask_logic_unit_inst (
    .exec       (exec),
    .logic_data (logic_data)
  );

  mask_set_first_unit mask_set_first_unit_inst (
    .exec           (exec),
    .set_first_data (set_first_data),
    .first_index    (first_index)
  );

  mask_popcount mask_popcount_inst (
    .exec      (exec),
    .pop_count (pop_count)
  );

  // only registered point between issue and ROB
  mask_result_stage mask_result_stage_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .exec           (exec),
    .logic_data     (logic_data),
    .set_first_data (set_first_data),
    .first_index    (first_index),
    .pop_count      (pop_count),
    .uop_valid      (uop_valid),
    .uop_ready      (uop_ready),
    .result_valid   (result_valid),
    .result_ready   (result_ready),
    .result         (result)
  );

endmodule

`default_nettype wire

// File: verilog/mask_unit_pkg.sv
`default_nettype none

package mask_unit_pkg;

  localparam int VLEN            = 128;
  localparam int XLEN            = 32;
  localparam int ROB_DEPTH_WIDTH = 3;
  // vl spans 0..VLEN inclusive
  localparam int VL_WIDTH        = 8;
  localparam int VSTART_WIDTH    = 7;

  // one value per supported operation
  typedef enum logic [3:0] {
    OP_NONE,
    OP_ANDN,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ORN,
    OP_NAND,
    OP_NOR,
    OP_XNOR,
    OP_MSBF,
    OP_MSIF,
    OP_MSOF,
    OP_CPOP,
    OP_FIRST
  } mask_op_e;

  // micro-op as issued, raw encoding fields
  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [2:0]                 funct3;
    logic [5:0]                 funct6;
    logic [4:0]                 vs1;
    logic [VSTART_WIDTH-1:0]    vstart;
    logic [VL_WIDTH-1:0]        vl;
    logic                       vm;
    logic [VLEN-1:0]            v0_data;
    logic [VLEN-1:0]            vd_data;
    logic [VLEN-1:0]            vs1_data;
    logic [VLEN-1:0]            vs2_data;
  } mask_uop_t;

  // decoded op with prepared sources
  typedef struct packed {
    mask_op_e                   op;
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [VSTART_WIDTH-1:0]    vstart;
    logic                       vm;
    logic [VLEN-1:0]            v0_data;
    logic [VLEN-1:0]            vd_data;
    logic [VLEN-1:0]            src1;
    logic [VLEN-1:0]            src2;
  } mask_exec_t;

  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [VLEN-1:0]            w_data;
  } rob_result_t;

endpackage

`default_nettype wire

// File: verilog/mask_uop_decode.sv
`timescale 1ns/100ps
`default_nettype none

module mask_uop_decode (
  input  mask_unit_pkg::mask_uop_t  uop,
  output mask_unit_pkg::mask_exec_t exec
);

  import mask_unit_pkg::*;
  import rvv_isa_pkg::*;

  funct3_e         funct3;
  funct6_e         funct6;
  vs1_op_e         vs1_op;
  mask_op_e        op;
  logic [VLEN-1:0] tail_mask;
  logic [VLEN-1:0] v0_mask;
  logic [VLEN-1:0] src1;
  logic [VLEN-1:0] src2;

  assign funct3 = funct3_e'(uop.funct3);
  assign funct6 = funct6_e'(uop.funct6);
  assign vs1_op = vs1_op_e'(uop.vs1);

  // everything kept here lives under OPMVV
  always_comb begin
    op = OP_NONE;
    if (funct3 == OPMVV) begin
      case (funct6)
        VMANDN:    op = OP_ANDN;
        VMAND:     op = OP_AND;
        VMOR:      op = OP_OR;
        VMXOR:     op = OP_XOR;
        VMORN:     op = OP_ORN;
        VMNAND:    op = OP_NAND;
        VMNOR:     op = OP_NOR;
        VMXNOR:    op = OP_XNOR;
        VWXUNARY0: begin
          case (vs1_op)
            VCPOP:   op = OP_CPOP;
            VFIRST:  op = OP_FIRST;
            default: op = OP_NONE;
          endcase
        end
        VMUNARY0: begin
          case (vs1_op)
            VMSBF:   op = OP_MSBF;
            VMSIF:   op = OP_MSIF;
            VMSOF:   op = OP_MSOF;
            default: op = OP_NONE;
          endcase
        end
        default:   op = OP_NONE;
      endcase
    end
  end

  // body elements, i < vl
  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      tail_mask[i] = (i < int'(uop.vl));
    end
  end

  // unmasked op behaves as if v0 were all ones
  assign v0_mask = uop.vm ? {VLEN{1'b1}} : uop.v0_data;

  always_comb begin
    src1 = '0;
    src2 = '0;
    case (op)
      OP_ANDN, OP_AND, OP_OR, OP_XOR,
      OP_ORN, OP_NAND, OP_NOR, OP_XNOR: begin
        src2 = uop.vs2_data;
        src1 = uop.vs1_data;
      end
      OP_MSBF, OP_MSIF, OP_MSOF: begin
        src2 = uop.vs2_data & v0_mask;
      end
      // scalar results also drop the tail
      OP_CPOP, OP_FIRST: begin
        src2 = uop.vs2_data & tail_mask & v0_mask;
      end
      default: begin
        src2 = '0;
      end
    endcase
  end

  always_comb begin
    exec.op        = op;
    exec.rob_entry = uop.rob_entry;
    exec.vstart    = uop.vstart;
    exec.vm        = uop.vm;
    exec.v0_data   = uop.v0_data;
    exec.vd_data   = uop.vd_data;
    exec.src1      = src1;
    exec.src2      = src2;
  end

endmodule

`default_nettype wire

// File: verilog/rvv_isa_pkg.sv
`default_nettype none

package rvv_isa_pkg;

  // operand category, bits [14:12] of the instruction
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } funct3_e;

  // mask-register logicals and the two unary groups under OPMVV
  typedef enum logic [5:0] {
    VWXUNARY0 = 6'b010000,
    VMUNARY0  = 6'b010100,
    VMANDN    = 6'b011000,
    VMAND     = 6'b011001,
    VMOR      = 6'b011010,
    VMXOR     = 6'b011011,
    VMORN     = 6'b011100,
    VMNAND    = 6'b011101,
    VMNOR     = 6'b011110,
    VMXNOR    = 6'b011111
  } funct6_e;

  // sub-opcode carried in the vs1 field of the unary groups
  typedef enum logic [4:0] {
    VMSBF  = 5'b00001,
    VMSOF  = 5'b00010,
    VMSIF  = 5'b00011,
    VCPOP  = 5'b10000,
    VFIRST = 5'b10001
  } vs1_op_e;

endpackage

`default_nettype wire
